// File: sources.f
verilog/loadPkg.sv
verilog/agu.sv
verilog/loadQueue.sv
verilog/loadAlign.sv
verilog/loadUnit.sv
test/loadUnit_sva.sv
test/loadUnitTb.sv

// File: run.sh
#!/bin/sh
# Build and run the load unit testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f sources.f \
    --top-module loadUnitTb \
    -o loadUnitSim

./obj_dir/loadUnitSim > sim.log 2>&1

cat sim.log

if grep -qF "*** PASSED ***" sim.log; then
    exit 0
fi
exit 1

// File: test/loadUnitTb.sv
module loadUnitTb
    import loadPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic              clk = 1'b0;
    logic              rst;
    logic              issueValid;
    loadOp_t           issueOp;
    logic [31:0]       srcA;
    logic [31:0]       srcB;
    logic [11:0]       imm;
    logic [TAG_W-1:0]  tagDst;
    logic [SQN_W-1:0]  sqN;
    logic              modeNoCregsRd;
    logic              modeRmask;
    logic [63:0]       rmask;
    logic              branchTaken;
    logic [SQN_W-1:0]  branchSqN;
    logic              memWe;
    logic [MEM_AW-1:0] memAddr;
    logic [31:0]       memWData;
    logic              resultStall;
    logic              resultValid;
    logic [TAG_W-1:0]  resultTag;
    logic [SQN_W-1:0]  resultSqN;
    logic [31:0]       resultData;
    logic              resultException;
    logic              resultDoNotCommit;

    logic [31:0]       memModel [MEM_WORDS];
    logic [31:0]       expData [$];
    logic [TAG_W-1:0]  expTag [$];
    logic [SQN_W-1:0]  expSqN [$];
    logic              expExc [$];
    logic              expDnc [$];
    logic [SQN_W-1:0]  nextSqN;
    string             testName;
    int                dataErrors;
    int                flagErrors;
    int                otherErrors;

    loadUnit dut (.*);

    bind loadQueue loadUnitSva sva (
        .clk(clk), .rst(rst), .full(full), .pop(pop), .wrPtr(wrPtr), .qValid(qValid)
    );

    always #2 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model and compares.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic void predictLoad(input loadOp_t op, input logic [31:0] a,
                                        input logic [31:0] b, input logic [11:0] im,
                                        output logic [31:0] data, output logic exc);
        logic [31:0] ea;
        logic [31:0] word;
        logic [7:0]  byteVal;
        logic [15:0] halfVal;
        begin
            ea = a + ((op >= LBRR) ? b : {{20{im[11]}}, im});
            word = memModel[ea[11:2]];
            byteVal = word[8*ea[1:0] +: 8];
            halfVal = ea[1] ? word[31:16] : word[15:0];
            exc = (ea == 32'd0);
            case (op)
                LB, LBRR: data = {{24{byteVal[7]}}, byteVal};
                LBU, LBURR: data = {24'd0, byteVal};
                LH, LHRR: data = {{16{halfVal[15]}}, halfVal};
                LHU, LHURR: data = {16'd0, halfVal};
                default: data = word;
            endcase
            if (op inside {LH, LHRR, LHU, LHURR} && ea[0]) exc = 1'b1;
            if (op inside {LW, LWRR, AMOSWAPW} && ea[1:0] != 2'b00) exc = 1'b1;
            if (modeNoCregsRd && ea[31:24] == 8'hFF) exc = 1'b1;
            if (modeRmask && rmask[ea[31:26]] == 1'b0) exc = 1'b1;
            if (exc) data = 32'd0;
        end
    endfunction

    function automatic bit isYounger(input logic [SQN_W-1:0] s, input logic [SQN_W-1:0] b);
        logic [SQN_W-1:0] d;
        begin
            d = s - b;
            return (d != '0) && !d[SQN_W-1];
        end
    endfunction

    task automatic checkResult(input logic [31:0] wantData, input logic [TAG_W-1:0] wantTag,
                               input logic [SQN_W-1:0] wantSqN);
        if (resultData !== wantData) begin
            dataErrors++;
            $display("Error %s: data expected %h actual %h", testName, wantData, resultData);
        end
        if (resultTag !== wantTag) begin
            dataErrors++;
            $display("Error %s: tag expected %0d actual %0d", testName, wantTag, resultTag);
        end
        if (resultSqN !== wantSqN) begin
            dataErrors++;
            $display("Error %s: sqN expected %0d actual %0d", testName, wantSqN, resultSqN);
        end
    endtask

    task automatic checkFlag(input string flagName, input logic want, input logic got);
        if (got !== want) begin
            flagErrors++;
            $display("Error %s: %s expected %b actual %b", testName, flagName, want, got);
        end
    endtask

    // results leave at a rising edge where the writeback is not stalled.
    always @(posedge clk) begin
        if (!rst && resultValid && !resultStall) begin
            if (expData.size() == 0) begin
                otherErrors++;
                $display("%s: a result with tag %0d arrived that was never expected",
                         testName, resultTag);
            end else begin
                checkResult(expData.pop_front(), expTag.pop_front(), expSqN.pop_front());
                checkFlag("exception", expExc.pop_front(), resultException);
                checkFlag("doNotCommit", expDnc.pop_front(), resultDoNotCommit);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // drivers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic preloadMemory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            @(negedge clk);
            memModel[i] = $urandom ^ (32'(i) << 20);
            memWe = 1'b1;
            memAddr = MEM_AW'(i);
            memWData = memModel[i];
        end
        @(negedge clk);
        memWe = 1'b0;
    endtask

    // holds the load until the agu can take it.
    task automatic issueLoad(input loadOp_t op, input logic [31:0] a,
                             input logic [31:0] b, input logic [11:0] im);
        logic [31:0] data;
        logic        exc;
        int          waited;
        begin
            @(negedge clk);
            issueValid = 1'b0;
            waited = 0;
            while (dut.queueFull && waited < 200) begin
                @(negedge clk);
                waited++;
            end
            if (waited >= 200) begin
                otherErrors++;
                $display("%s: the queue never made room for a new load", testName);
            end
            predictLoad(op, a, b, im, data, exc);
            issueValid = 1'b1;
            issueOp = op;
            srcA = a;
            srcB = b;
            imm = im;
            sqN = nextSqN;
            tagDst = nextSqN[TAG_W-1:0];
            expData.push_back(data);
            expTag.push_back(nextSqN[TAG_W-1:0]);
            expSqN.push_back(nextSqN);
            expExc.push_back(exc);
            expDnc.push_back(op == AMOSWAPW);
            nextSqN++;
        end
    endtask

    task automatic drainResults();
        int waited;
        begin
            @(negedge clk);
            issueValid = 1'b0;
            waited = 0;
            while (expData.size() != 0 && waited < 300) begin
                @(negedge clk);
                waited++;
            end
            if (expData.size() != 0) begin
                otherErrors++;
                $display("%s: timed out with %0d results still missing",
                         testName, expData.size());
            end
            repeat (4) @(negedge clk);          // catch stray results.
        end
    endtask

    function automatic logic [31:0] randomBase();
        return 32'h1000 + ($urandom & 32'hFFC);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic allOpcodesTest();
        loadOp_t     op;
        logic [31:0] offs;
        begin
            testName = "allOpcodes";
            for (int k = 0; k < 4; k++) begin
                for (int o = 0; o <= int'(AMOSWAPW); o++) begin
                    op = loadOp_t'(o);
                    offs = 32'($urandom & 32'h3F) & 32'hFFFF_FFFC;
                    if (op inside {LB, LBU, LBRR, LBURR}) offs += 32'($urandom & 3);
                    if (op inside {LH, LHU, LHRR, LHURR}) offs += 32'($urandom & 2);
                    issueLoad(op, randomBase(), offs, offs[11:0]);
                end
            end
            drainResults();
        end
    endtask

    task automatic exceptionTest();
        testName = "exceptions";
        issueLoad(LW, 32'd0, 32'd0, 12'd0);
        issueLoad(LH, randomBase(), 32'd0, 12'd1);
        issueLoad(LHU, randomBase(), 32'd0, 12'd3);
        issueLoad(LWRR, randomBase(), 32'd2, 12'd0);
        issueLoad(LB, randomBase(), 32'd0, 12'd3);        // bytes may sit anywhere.
        drainResults();
    endtask

    task automatic modeTest();
        testName = "modes";
        @(negedge clk);
        modeNoCregsRd = 1'b1;
        modeRmask = 1'b1;
        rmask = ~(64'd1 << 16);
        issueLoad(LW, 32'hFF00_0100, 32'd0, 12'd0);
        issueLoad(LW, 32'h4000_0200, 32'd0, 12'd0);
        drainResults();
        modeNoCregsRd = 1'b0;
        modeRmask = 1'b0;
        issueLoad(LW, 32'hFF00_0100, 32'd0, 12'd0);
        issueLoad(LW, 32'h4000_0200, 32'd0, 12'd0);
        drainResults();
        rmask = '1;
    endtask

    task automatic stallTest();
        testName = "stall";
        fork
            for (int i = 0; i < 9; i++) issueLoad(LW, randomBase(), 32'd0, 12'd0);
            begin
                repeat (4) @(negedge clk);
                resultStall = 1'b1;             // first result is held.
                repeat (25) @(negedge clk);
                resultStall = 1'b0;
            end
        join
        drainResults();
    endtask

    task automatic branchTest();
        logic [SQN_W-1:0] brSqN;
        logic [31:0]      keepData [$];
        logic [TAG_W-1:0] keepTag [$];
        logic [SQN_W-1:0] keepSqN [$];
        logic             keepExc [$];
        logic             keepDnc [$];
        begin
            testName = "branch";
            @(negedge clk);
            resultStall = 1'b1;
            brSqN = nextSqN + SQN_W'(1);                // two older, three younger.
            for (int i = 0; i < 5; i++) issueLoad(LBU, randomBase(), 32'd0, 12'd1);
            @(negedge clk);
            issueValid = 1'b0;
            branchTaken = 1'b1;
            branchSqN = brSqN;
            for (int i = 0; i < expData.size(); i++) begin
                if (!isYounger(expSqN[i], brSqN)) begin
                    keepData.push_back(expData[i]);
                    keepTag.push_back(expTag[i]);
                    keepSqN.push_back(expSqN[i]);
                    keepExc.push_back(expExc[i]);
                    keepDnc.push_back(expDnc[i]);
                end
            end
            expData = keepData;
            expTag = keepTag;
            expSqN = keepSqN;
            expExc = keepExc;
            expDnc = keepDnc;
            @(negedge clk);
            branchTaken = 1'b0;
            resultStall = 1'b0;
            issueLoad(LW, randomBase(), 32'd0, 12'd4);  // refetched path.
            drainResults();
        end
    endtask

    initial begin
        #500us;
        $display("simulation watchdog expired");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(32'hc34e98a1));
        rst = 1'b1;
        issueValid = 1'b0;
        issueOp = LB;
        srcA = '0;
        srcB = '0;
        imm = '0;
        tagDst = '0;
        sqN = '0;
        modeNoCregsRd = 1'b0;
        modeRmask = 1'b0;
        rmask = '1;
        branchTaken = 1'b0;
        branchSqN = '0;
        memWe = 1'b0;
        memAddr = '0;
        memWData = '0;
        resultStall = 1'b0;
        nextSqN = '0;
        dataErrors = 0;
        flagErrors = 0;
        otherErrors = 0;
        testName = "reset";
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        preloadMemory();
        allOpcodesTest();
        exceptionTest();
        modeTest();
        stallTest();
        branchTest();

        $display("errors: %0d data, %0d flag, %0d other", dataErrors, flagErrors, otherErrors);
        if (dataErrors + flagErrors + otherErrors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: test/loadUnit_sva.sv
module loadUnitSva
    import loadPkg::*;
(
    input logic              clk,
    input logic              rst,
    input logic              full,
    input logic              pop,
    input logic [QPTR_W-1:0] wrPtr,
    input logic              qValid
);

    timeunit 1ns;
    timeprecision 100ps;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // queue control checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    fullKnown: assert property (@(posedge clk) disable iff (rst) !$isunknown(full))
        else $error("queue full flag is unknown");

    popKnown: assert property (@(posedge clk) disable iff (rst) !$isunknown(pop))
        else $error("queue pop is unknown");

    // a full queue takes nothing.
    noPushWhenFull: assert property (@(posedge clk) disable iff (rst) full |=> $stable(wrPtr))
        else $error("push accepted while the queue is full");

    qValidAfterReset: assert property (@(posedge clk) rst |=> !qValid)
        else $error("qValid still high one cycle into reset");

endmodule

// File: verilog/loadUnit.sv
module loadUnit
    import loadPkg::*;
(
    input  logic              clk,
    input  logic              rst,

    input  logic              issueValid,
    input  loadOp_t           issueOp,
    input  logic [31:0]       srcA,
    input  logic [31:0]       srcB,
    input  logic [11:0]       imm,
    input  logic [TAG_W-1:0]  tagDst,
    input  logic [SQN_W-1:0]  sqN,

    input  logic              modeNoCregsRd,
    input  logic              modeRmask,
    input  logic [63:0]       rmask,

    input  logic              branchTaken,
    input  logic [SQN_W-1:0]  branchSqN,

    input  logic              memWe,
    input  logic [MEM_AW-1:0] memAddr,
    input  logic [31:0]       memWData,

    input  logic              resultStall,
    output logic              resultValid,
    output logic [TAG_W-1:0]  resultTag,
    output logic [SQN_W-1:0]  resultSqN,
    output logic [31:0]       resultData,
    output logic              resultException,
    output logic              resultDoNotCommit
);

    logic             aguValid;
    logic [31:0]      aguAddr;
    logic [1:0]       aguSize;
    logic [1:0]       aguShamt;
    logic             aguSignExtend;
    logic             aguException;
    logic             aguDoNotCommit;
    logic [TAG_W-1:0] aguTag;
    logic [SQN_W-1:0] aguSqN;
    logic             queueFull;            // also the agu stall.

    logic             qValid;
    logic [31:0]      qAddr;
    logic [1:0]       qSize;
    logic [1:0]       qShamt;
    logic             qSignExtend;
    logic             qException;
    logic             qDoNotCommit;
    logic [TAG_W-1:0] qTag;
    logic [SQN_W-1:0] qSqN;
    logic             pop;

    agu agu (
        .clk(clk), .rst(rst), .en(1'b1), .stall(queueFull),
        .modeNoCregsRd(modeNoCregsRd), .modeRmask(modeRmask), .rmask(rmask),
        .branchTaken(branchTaken), .branchSqN(branchSqN),
        .issueValid(issueValid), .issueOp(issueOp), .srcA(srcA), .srcB(srcB),
        .imm(imm), .tagDst(tagDst), .sqN(sqN),
        .aguValid(aguValid), .aguAddr(aguAddr), .aguSize(aguSize),
        .aguShamt(aguShamt), .aguSignExtend(aguSignExtend),
        .aguException(aguException), .aguDoNotCommit(aguDoNotCommit),
        .aguTag(aguTag), .aguSqN(aguSqN)
    );

    loadQueue loadQueue (
        .clk(clk), .rst(rst),
        .pushValid(aguValid), .pushAddr(aguAddr), .pushSize(aguSize),
        .pushShamt(aguShamt), .pushSignExtend(aguSignExtend),
        .pushException(aguException), .pushDoNotCommit(aguDoNotCommit),
        .pushTag(aguTag), .pushSqN(aguSqN), .full(queueFull),
        .branchTaken(branchTaken), .branchSqN(branchSqN),
        .pop(pop), .qValid(qValid), .qAddr(qAddr), .qSize(qSize),
        .qShamt(qShamt), .qSignExtend(qSignExtend), .qException(qException),
        .qDoNotCommit(qDoNotCommit), .qTag(qTag), .qSqN(qSqN)
    );

    loadAlign loadAlign (
        .clk(clk), .rst(rst),
        .qValid(qValid), .qAddr(qAddr), .qSize(qSize), .qShamt(qShamt),
        .qSignExtend(qSignExtend), .qException(qException),
        .qDoNotCommit(qDoNotCommit), .qTag(qTag), .qSqN(qSqN), .pop(pop),
        .resultStall(resultStall), .branchTaken(branchTaken), .branchSqN(branchSqN),
        .memWe(memWe), .memAddr(memAddr), .memWData(memWData),
        .resultValid(resultValid), .resultTag(resultTag), .resultSqN(resultSqN),
        .resultData(resultData), .resultException(resultException),
        .resultDoNotCommit(resultDoNotCommit)
    );

endmodule

// File: verilog/loadAlign.sv
module loadAlign
    import loadPkg::*;
(
    input  logic              clk,
    input  logic              rst,

    input  logic              qValid,
    input  logic [31:0]       qAddr,
    input  logic [1:0]        qSize,
    input  logic [1:0]        qShamt,
    input  logic              qSignExtend,
    input  logic              qException,
    input  logic              qDoNotCommit,
    input  logic [TAG_W-1:0]  qTag,
    input  logic [SQN_W-1:0]  qSqN,
    output logic              pop,

    input  logic              resultStall,
    input  logic              branchTaken,
    input  logic [SQN_W-1:0]  branchSqN,

    input  logic              memWe,
    input  logic [MEM_AW-1:0] memAddr,
    input  logic [31:0]       memWData,

    output logic              resultValid,
    output logic [TAG_W-1:0]  resultTag,
    output logic [SQN_W-1:0]  resultSqN,
    output logic [31:0]       resultData,
    output logic              resultException,
    output logic              resultDoNotCommit
);

    logic [31:0]      mem [MEM_WORDS];
    logic [31:0]      rdWord;
    logic [31:0]      shifted;
    logic [31:0]      aligned;
    logic [SQN_W-1:0] headDelta;
    logic [SQN_W-1:0] resultDelta;
    logic             headSquash;
    logic             resultSquash;

    assign pop = qValid && !resultStall;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read and align.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign rdWord = mem[qAddr[MEM_AW+1:2]];
    assign shifted = rdWord >> {qShamt, 3'b000};

    always_comb begin
        case (qSize)
            2'd0: aligned = {{24{qSignExtend & shifted[7]}}, shifted[7:0]};
            2'd1: aligned = {{16{qSignExtend & shifted[15]}}, shifted[15:0]};
            default: aligned = shifted;
        endcase
        if (qException) aligned = 32'd0;    // faulting loads return zero.
    end

    assign headDelta = qSqN - branchSqN;
    assign resultDelta = resultSqN - branchSqN;
    assign headSquash = branchTaken && ($signed(headDelta) > 0);
    assign resultSquash = resultValid && branchTaken && ($signed(resultDelta) > 0);

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else if (!resultStall) begin
            resultValid <= pop && !headSquash;
        end else if (resultSquash) begin
            resultValid <= 1'b0;            // held result flushed.
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            resultTag <= qTag;
            resultSqN <= qSqN;
            resultData <= aligned;
            resultException <= qException;
            resultDoNotCommit <= qDoNotCommit;
        end
    end

    // preload port.
    always_ff @(posedge clk) begin
        if (memWe) mem[memAddr] <= memWData;
    end

endmodule

// File: verilog/loadQueue.sv
module loadQueue
    import loadPkg::*;
(
    input  logic             clk,
    input  logic             rst,

    input  logic             pushValid,
    input  logic [31:0]      pushAddr,
    input  logic [1:0]       pushSize,
    input  logic [1:0]       pushShamt,
    input  logic             pushSignExtend,
    input  logic             pushException,
    input  logic             pushDoNotCommit,
    input  logic [TAG_W-1:0] pushTag,
    input  logic [SQN_W-1:0] pushSqN,
    output logic             full,

    input  logic             branchTaken,
    input  logic [SQN_W-1:0] branchSqN,

    input  logic             pop,
    output logic             qValid,
    output logic [31:0]      qAddr,
    output logic [1:0]       qSize,
    output logic [1:0]       qShamt,
    output logic             qSignExtend,
    output logic             qException,
    output logic             qDoNotCommit,
    output logic [TAG_W-1:0] qTag,
    output logic [SQN_W-1:0] qSqN
);

    logic                   entValid [QUEUE_DEPTH];
    logic [31:0]            entAddr [QUEUE_DEPTH];
    logic [1:0]             entSize [QUEUE_DEPTH];
    logic [1:0]             entShamt [QUEUE_DEPTH];
    logic                   entSign [QUEUE_DEPTH];
    logic                   entExc [QUEUE_DEPTH];
    logic                   entDnc [QUEUE_DEPTH];
    logic [TAG_W-1:0]       entTag [QUEUE_DEPTH];
    logic [SQN_W-1:0]       entSqN [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0] entSquash;

    logic [QPTR_W-1:0]      rdPtr;
    logic [QPTR_W-1:0]      wrPtr;
    logic [QPTR_W:0]        count;
    logic                   empty;
    logic                   doPush;
    logic                   doRetire;
    logic [SQN_W-1:0]       pushDelta;
    logic                   pushSquash;

    assign empty = (count == '0);
    assign full = (count == (QPTR_W+1)'(QUEUE_DEPTH));
    assign doPush = pushValid && !full;

    // dead heads drain on their own, one per cycle.
    assign qValid = !empty && entValid[rdPtr];
    assign doRetire = !empty && (pop || !entValid[rdPtr]);

    assign pushDelta = pushSqN - branchSqN;
    assign pushSquash = branchTaken && ($signed(pushDelta) > 0);

    always_comb begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            entSquash[i] = branchTaken && ($signed(entSqN[i] - branchSqN) > 0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
            for (int i = 0; i < QUEUE_DEPTH; i++) entValid[i] <= 1'b0;
        end else begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                if (entSquash[i]) entValid[i] <= 1'b0;
            end
            if (doPush) begin
                entValid[wrPtr] <= !pushSquash;     // push wins over the sweep.
                wrPtr <= wrPtr + QPTR_W'(1);
            end
            if (doRetire) rdPtr <= rdPtr + QPTR_W'(1);
            count <= count + (QPTR_W+1)'(doPush) - (QPTR_W+1)'(doRetire);
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            entAddr[wrPtr] <= pushAddr;
            entSize[wrPtr] <= pushSize;
            entShamt[wrPtr] <= pushShamt;
            entSign[wrPtr] <= pushSignExtend;
            entExc[wrPtr] <= pushException;
            entDnc[wrPtr] <= pushDoNotCommit;
            entTag[wrPtr] <= pushTag;
            entSqN[wrPtr] <= pushSqN;
        end
    end

    assign qAddr = entAddr[rdPtr];
    assign qSize = entSize[rdPtr];
    assign qShamt = entShamt[rdPtr];
    assign qSignExtend = entSign[rdPtr];
    assign qException = entExc[rdPtr];
    assign qDoNotCommit = entDnc[rdPtr];
    assign qTag = entTag[rdPtr];
    assign qSqN = entSqN[rdPtr];

endmodule

// File: verilog/agu.sv
module agu
    import loadPkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             en,
    input  logic             stall,

    input  logic             modeNoCregsRd,
    input  logic             modeRmask,
    input  logic [63:0]      rmask,

    input  logic             branchTaken,
    input  logic [SQN_W-1:0] branchSqN,

    input  logic             issueValid,
    input  loadOp_t          issueOp,
    input  logic [31:0]      srcA,
    input  logic [31:0]      srcB,
    input  logic [11:0]      imm,
    input  logic [TAG_W-1:0] tagDst,
    input  logic [SQN_W-1:0] sqN,

    output logic             aguValid,
    output logic [31:0]      aguAddr,
    output logic [1:0]       aguSize,
    output logic [1:0]       aguShamt,
    output logic             aguSignExtend,
    output logic             aguException,
    output logic             aguDoNotCommit,
    output logic [TAG_W-1:0] aguTag,
    output logic [SQN_W-1:0] aguSqN
);

    logic [31:0]      offset;
    logic [31:0]      addr;
    logic [1:0]       nextSize;
    logic [1:0]       nextShamt;
    logic             nextSign;
    logic             misaligned;
    logic             nextException;
    logic [SQN_W-1:0] issueDelta;
    logic [SQN_W-1:0] heldDelta;
    logic             capture;
    logic             squashHeld;

    assign offset = (issueOp >= LBRR) ? srcB : {{20{imm[11]}}, imm};
    assign addr = srcA + offset;

    // size 0 byte, 1 half, 2 word.
    always_comb begin
        nextSize = 2'd2;
        nextShamt = 2'd0;
        nextSign = 1'b0;
        case (issueOp)
            LB, LBRR: begin
                nextSize = 2'd0;
                nextShamt = addr[1:0];
                nextSign = 1'b1;
            end
            LBU, LBURR: begin
                nextSize = 2'd0;
                nextShamt = addr[1:0];
            end
            LH, LHRR: begin
                nextSize = 2'd1;
                nextShamt = {addr[1], 1'b0};
                nextSign = 1'b1;
            end
            LHU, LHURR: begin
                nextSize = 2'd1;
                nextShamt = {addr[1], 1'b0};
            end
            default: begin                  // LW, LWRR and AMOSWAPW.
                nextSize = 2'd2;
            end
        endcase
    end

    assign misaligned = ((nextSize == 2'd1) && addr[0]) ||
                        ((nextSize == 2'd2) && (addr[1:0] != 2'b00));

    assign nextException = (addr == 32'd0) || misaligned ||
                           ((addr[31:24] == CREG_PAGE) && modeNoCregsRd) ||
                           (modeRmask && !rmask[addr[31:26]]);

    // younger than the branch when the wrapped difference is positive.
    assign issueDelta = sqN - branchSqN;
    assign heldDelta = aguSqN - branchSqN;

    assign capture = !stall && en && issueValid &&
                     !(branchTaken && ($signed(issueDelta) > 0));
    assign squashHeld = aguValid && branchTaken && ($signed(heldDelta) > 0);

    always_ff @(posedge clk) begin
        if (rst) begin
            aguValid <= 1'b0;
        end else if (capture) begin
            aguValid <= 1'b1;
        end else if (!stall || squashHeld) begin
            aguValid <= 1'b0;               // consumed or flushed.
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            aguAddr <= addr;
            aguSize <= nextSize;
            aguShamt <= nextShamt;
            aguSignExtend <= nextSign;
            aguException <= nextException;
            aguDoNotCommit <= (issueOp == AMOSWAPW);
            aguTag <= tagDst;
            aguSqN <= sqN;
        end
    end

endmodule

// File: verilog/loadPkg.sv
package loadPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths and depths.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int SQN_W = 7;               // sequence number, wraps.
    localparam int TAG_W = 6;               // physical destination tag.

    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W = $clog2(QUEUE_DEPTH);

    // data memory is word wide, indexed by addr[11:2].
    localparam int MEM_WORDS = 1024;
    localparam int MEM_AW = $clog2(MEM_WORDS);

    // control registers live in the top page.
    localparam logic [7:0] CREG_PAGE = 8'hFF;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // load opcodes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // order matters: everything from LBRR on takes srcB as the offset.
    typedef enum logic [3:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        LBRR,
        LHRR,
        LWRR,
        LBURR,
        LHURR,
        AMOSWAPW                            // word load, never commits.
    } loadOp_t;

endpackage
